//--- csr_unit.f
hw/csr_pkg.sv
hw/csr_regs.sv
hw/csr_op_unit.sv
hw/trap_ctrl.sv
hw/csr_unit.sv
tests/csr_unit_assert.sv
tests/csr_unit_tb.sv

//--- hw/csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit (
    input  logic               csr_valid,
    input  csr_pkg::csr_op_e   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_src,
    input  csr_pkg::xlen_t     old_value,
    input  logic               rhit,
    output csr_pkg::csr_addr_t waddr,
    output csr_pkg::xlen_t     wdata,
    output logic               wen,
    output logic               illegal_csr
);

    import csr_pkg::*;

    xlen_t new_value;

    // Read-modify-write on the value read this cycle
    always_comb begin
        case (csr_op)
            CSR_RW: begin
                new_value = csr_src;
            end
            CSR_RS: begin
                new_value = old_value | csr_src;
            end
            CSR_RC: begin
                new_value = old_value & ~csr_src;
            end
            default: begin
                new_value = old_value;
            end
        endcase
    end

    assign waddr = csr_addr;
    assign wdata = new_value;

    // Set and clear always write, even with a zero source
    assign wen = csr_valid & rhit;

    // A miss goes to the trap controller in the same cycle
    assign illegal_csr = csr_valid & ~rhit;

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    // Data word, CSR address and exception code
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0] cause_t;

    // Encoded as the funct3 of the register CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_SAVE_EPC    = 3'd1,
        ST_SAVE_CAUSE  = 3'd2,
        ST_TRAP_STATUS = 3'd3,
        ST_MRET_STATUS = 3'd4
    } trap_state_e;

    // Machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // MPP = machine mode
    localparam xlen_t MSTATUS_RESET = 32'h0000_1800;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam cause_t CAUSE_ILLEGAL_INSN = 4'd2;

endpackage

`default_nettype wire

//--- hw/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t raddr,
    output csr_pkg::xlen_t     rdata,
    input  csr_pkg::csr_addr_t waddr1,
    input  csr_pkg::csr_addr_t waddr2,
    input  csr_pkg::xlen_t     wdata1,
    input  csr_pkg::xlen_t     wdata2,
    input  logic               wen1,
    input  logic               wen2,
    output logic               rhit,
    output csr_pkg::xlen_t     mstatus_q,
    output csr_pkg::xlen_t     mtvec_q,
    output csr_pkg::xlen_t     mepc_q
);

    import csr_pkg::*;

    xlen_t mcause_q;

    // Read decode, unknown addresses read zero and miss
    always_comb begin
        rdata = '0;
        rhit  = 1'b1;
        case (raddr)
            CSR_MSTATUS: begin
                rdata = mstatus_q;
            end
            CSR_MTVEC: begin
                rdata = mtvec_q;
            end
            CSR_MEPC: begin
                rdata = mepc_q;
            end
            CSR_MCAUSE: begin
                rdata = mcause_q;
            end
            default: begin
                rhit = 1'b0;
            end
        endcase
    end

    // Port 2 is applied last so it overrides port 1 on the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q <= MSTATUS_RESET;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (wen1) begin
                case (waddr1)
                    CSR_MSTATUS: begin
                        mstatus_q <= wdata1;
                    end
                    CSR_MTVEC: begin
                        mtvec_q <= wdata1;
                    end
                    CSR_MEPC: begin
                        mepc_q <= wdata1;
                    end
                    CSR_MCAUSE: begin
                        mcause_q <= wdata1;
                    end
                    default: begin
                    end
                endcase
            end
            if (wen2) begin
                case (waddr2)
                    CSR_MSTATUS: begin
                        mstatus_q <= wdata2;
                    end
                    CSR_MTVEC: begin
                        mtvec_q <= wdata2;
                    end
                    CSR_MEPC: begin
                        mepc_q <= wdata2;
                    end
                    CSR_MCAUSE: begin
                        mcause_q <= wdata2;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               csr_valid,
    input  csr_pkg::csr_op_e   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_src,
    input  csr_pkg::xlen_t     pc,
    input  logic               exc_valid,
    input  csr_pkg::cause_t    exc_cause,
    input  logic               mret_valid,
    output csr_pkg::xlen_t     csr_rdata,
    output logic               busy,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc
);

    import csr_pkg::*;

    logic      rhit;
    logic      illegal_csr;
    csr_addr_t waddr1;
    csr_addr_t waddr2;
    xlen_t     wdata1;
    xlen_t     wdata2;
    logic      wen1;
    logic      wen2;
    xlen_t     mstatus_q;
    xlen_t     mtvec_q;
    xlen_t     mepc_q;

    csr_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr     (csr_addr),
        .rdata     (csr_rdata),
        .waddr1    (waddr1),
        .waddr2    (waddr2),
        .wdata1    (wdata1),
        .wdata2    (wdata2),
        .wen1      (wen1),
        .wen2      (wen2),
        .rhit      (rhit),
        .mstatus_q (mstatus_q),
        .mtvec_q   (mtvec_q),
        .mepc_q    (mepc_q)
    );

    // The read data doubles as the old value for set and clear
    csr_op_unit u_op (
        .csr_valid   (csr_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_src     (csr_src),
        .old_value   (csr_rdata),
        .rhit        (rhit),
        .waddr       (waddr1),
        .wdata       (wdata1),
        .wen         (wen1),
        .illegal_csr (illegal_csr)
    );

    trap_ctrl u_trap (
        .clk            (clk),
        .rst_n          (rst_n),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .illegal_csr    (illegal_csr),
        .mret_valid     (mret_valid),
        .pc             (pc),
        .mstatus_q      (mstatus_q),
        .mtvec_q        (mtvec_q),
        .mepc_q         (mepc_q),
        .waddr          (waddr2),
        .wdata          (wdata2),
        .wen            (wen2),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- hw/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exc_valid,
    input  csr_pkg::cause_t    exc_cause,
    input  logic               illegal_csr,
    input  logic               mret_valid,
    input  csr_pkg::xlen_t     pc,
    input  csr_pkg::xlen_t     mstatus_q,
    input  csr_pkg::xlen_t     mtvec_q,
    input  csr_pkg::xlen_t     mepc_q,
    output csr_pkg::csr_addr_t waddr,
    output csr_pkg::xlen_t     wdata,
    output logic               wen,
    output logic               busy,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc
);

    import csr_pkg::*;

    trap_state_e state_q;
    trap_state_e state_d;
    xlen_t       epc_q;
    cause_t      cause_q;
    logic        trap_take;
    logic        mret_take;
    xlen_t       trap_status;
    xlen_t       mret_status;

    // Exception beats an illegal access, both beat mret
    assign trap_take = (state_q == ST_IDLE) & (exc_valid | illegal_csr);
    assign mret_take = (state_q == ST_IDLE) & ~exc_valid & ~illegal_csr & mret_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (trap_take) begin
                    state_d = ST_SAVE_EPC;
                end else if (mret_take) begin
                    state_d = ST_MRET_STATUS;
                end
            end
            ST_SAVE_EPC: begin
                state_d = ST_SAVE_CAUSE;
            end
            ST_SAVE_CAUSE: begin
                state_d = ST_TRAP_STATUS;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Trap payload captured on acceptance
    always_ff @(posedge clk) begin
        if (trap_take) begin
            epc_q   <= pc;
            cause_q <= exc_valid ? exc_cause : CAUSE_ILLEGAL_INSN;
        end
    end

    // mstatus stack push on trap entry, pop on mret
    always_comb begin
        trap_status               = mstatus_q;
        trap_status[MSTATUS_MPIE] = mstatus_q[MSTATUS_MIE];
        trap_status[MSTATUS_MIE]  = 1'b0;
        mret_status               = mstatus_q;
        mret_status[MSTATUS_MIE]  = mstatus_q[MSTATUS_MPIE];
        mret_status[MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        waddr          = CSR_MSTATUS;
        wdata          = '0;
        wen            = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        case (state_q)
            ST_SAVE_EPC: begin
                waddr = CSR_MEPC;
                wdata = epc_q;
                wen   = 1'b1;
            end
            ST_SAVE_CAUSE: begin
                waddr = CSR_MCAUSE;
                wdata = xlen_t'(cause_q);
                wen   = 1'b1;
            end
            ST_TRAP_STATUS: begin
                wdata          = trap_status;
                wen            = 1'b1;
                redirect_valid = 1'b1;
                redirect_pc    = mtvec_q;
            end
            ST_MRET_STATUS: begin
                wdata          = mret_status;
                wen            = 1'b1;
                redirect_valid = 1'b1;
                redirect_pc    = mepc_q;
            end
            default: begin
            end
        endcase
    end

    assign busy = (state_q != ST_IDLE);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb \
    --Mdir obj_dir \
    -f csr_unit.f

./obj_dir/Vcsr_unit_tb

//--- tests/csr_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assert (
    input logic clk,
    input logic rst_n,
    input logic csr_valid,
    input logic busy,
    input logic redirect_valid
);

    // The redirect is a single-cycle pulse
    redirect_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) redirect_valid |=> !redirect_valid
    ) else $error("redirect_valid held for more than one cycle");

    no_op_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) !(csr_valid && busy)
    ) else $error("csr_valid raised while the trap controller is busy");

    // Synchronous reset leaves the controller idle
    idle_after_reset: assert property (
        @(posedge clk) !rst_n |=> !busy && !redirect_valid
    ) else $error("busy or redirect_valid high in the cycle after reset");

endmodule

bind csr_unit csr_unit_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_valid      (csr_valid),
    .busy           (busy),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD = 4;

    typedef enum logic [1:0] {K_CSR, K_EXC, K_MRET, K_IDLE} kind_e;

    typedef struct packed {
        kind_e     kind;
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     data;
        xlen_t     pc;
        cause_t    cause;
        logic      nest;
    } entry_t;

    logic      clk;
    logic      rst_n;
    logic      csr_valid;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    xlen_t     csr_src;
    xlen_t     pc;
    logic      exc_valid;
    cause_t    exc_cause;
    logic      mret_valid;
    xlen_t     csr_rdata;
    logic      busy;
    logic      redirect_valid;
    xlen_t     redirect_pc;

    entry_t entries[$];
    string  names[$];
    bit     table_ready = 1'b0;

    // Reference copies of the four CSRs
    xlen_t m_status;
    xlen_t m_tvec;
    xlen_t m_epc;
    xlen_t m_cause;

    csr_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    function automatic xlen_t model_read(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS: return m_status;
            CSR_MTVEC:   return m_tvec;
            CSR_MEPC:    return m_epc;
            CSR_MCAUSE:  return m_cause;
            default:     return '0;
        endcase
    endfunction

    function automatic logic model_hit(input csr_addr_t addr);
        return addr inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
    endfunction

    function automatic xlen_t apply_op(input csr_op_e op, input xlen_t old, input xlen_t src);
        case (op)
            CSR_RS:  return old | src;
            CSR_RC:  return old & ~src;
            default: return src;
        endcase
    endfunction

    task automatic model_write(input csr_addr_t addr, input xlen_t value);
        case (addr)
            CSR_MSTATUS: m_status = value;
            CSR_MTVEC:   m_tvec = value;
            CSR_MEPC:    m_epc = value;
            CSR_MCAUSE:  m_cause = value;
            default: begin
            end
        endcase
    endtask

    // Trap entry pushes MIE into MPIE and disables interrupts
    task automatic model_trap(input xlen_t epc, input cause_t cause);
        m_epc = epc;
        m_cause = {28'd0, cause};
        m_status[MSTATUS_MPIE] = m_status[MSTATUS_MIE];
        m_status[MSTATUS_MIE] = 1'b0;
    endtask

    task automatic add_entry(input string name, input kind_e kind, input csr_op_e op,
                             input csr_addr_t addr, input xlen_t data, input cause_t cause,
                             input logic nest);
        entry_t e;
        e.kind = kind;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.pc = $urandom() & 32'hffff_fffc;
        e.cause = cause;
        e.nest = nest;
        entries.push_back(e);
        names.push_back(name);
    endtask

    // Set with a zero source reads without changing the register
    task automatic add_reads(input string tag);
        add_entry({tag, " read mstatus"}, K_CSR, CSR_RS, CSR_MSTATUS, '0, '0, 1'b0);
        add_entry({tag, " read mtvec"}, K_CSR, CSR_RS, CSR_MTVEC, '0, '0, 1'b0);
        add_entry({tag, " read mepc"}, K_CSR, CSR_RS, CSR_MEPC, '0, '0, 1'b0);
        add_entry({tag, " read mcause"}, K_CSR, CSR_RS, CSR_MCAUSE, '0, '0, 1'b0);
    endtask

    task automatic build_table();
        csr_addr_t regs[4];
        regs = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
        add_reads("reset");
        foreach (regs[r]) begin
            add_entry($sformatf("rw %h", regs[r]), K_CSR, CSR_RW, regs[r], $urandom, '0, 1'b0);
            add_entry($sformatf("rw %h read", regs[r]), K_CSR, CSR_RS, regs[r], '0, '0, 1'b0);
            add_entry($sformatf("rs %h", regs[r]), K_CSR, CSR_RS, regs[r], $urandom, '0, 1'b0);
            add_entry($sformatf("rs %h read", regs[r]), K_CSR, CSR_RS, regs[r], '0, '0, 1'b0);
            add_entry($sformatf("rc %h", regs[r]), K_CSR, CSR_RC, regs[r], $urandom, '0, 1'b0);
            add_entry($sformatf("rc %h read", regs[r]), K_CSR, CSR_RS, regs[r], '0, '0, 1'b0);
        end
        add_entry("set mtvec", K_CSR, CSR_RW, CSR_MTVEC, $urandom & 32'hffff_fffc, '0, 1'b0);
        add_entry("illegal csr", K_CSR, CSR_RW, 12'h7c0, $urandom, '0, 1'b0);
        add_reads("illegal");
        // MIE set with MPIE clear so the trap has to move MIE into MPIE
        add_entry("mie on", K_CSR, CSR_RW, CSR_MSTATUS, 32'h0000_1808, '0, 1'b0);
        add_entry("exception", K_EXC, CSR_RW, '0, '0, cause_t'($urandom), 1'b0);
        add_reads("exception");
        add_entry("mret", K_MRET, CSR_RW, '0, '0, '0, 1'b0);
        add_reads("mret");
        add_entry("mie mpie off", K_CSR, CSR_RC, CSR_MSTATUS, 32'h88, '0, 1'b0);
        add_entry("mret mpie zero", K_MRET, CSR_RW, '0, '0, '0, 1'b0);
        add_entry("idle", K_IDLE, CSR_RW, '0, '0, '0, 1'b0);
        add_entry("mie on again", K_CSR, CSR_RS, CSR_MSTATUS, 32'h8, '0, 1'b0);
        add_entry("nested exception", K_EXC, CSR_RW, '0, '0, cause_t'($urandom), 1'b1);
        add_reads("nested exception");
        add_entry("nested mret", K_MRET, CSR_RW, '0, '0, '0, 1'b1);
        add_reads("nested mret");
        add_entry("final idle", K_IDLE, CSR_RW, '0, '0, '0, 1'b0);
    endtask

    task automatic clear_strobes();
        csr_valid  <= 1'b0;
        exc_valid  <= 1'b0;
        mret_valid <= 1'b0;
    endtask

    // Counts cycles from acceptance to the redirect pulse
    task automatic wait_redirect(input string name, input int cycles, input logic nest);
        int n;
        n = 0;
        while (redirect_valid !== 1'b1) begin
            @(posedge clk);
            clear_strobes();
            n++;
            // A second trap source while busy must be dropped
            if (nest && n == 1) begin
                exc_valid  <= 1'b1;
                exc_cause  <= cause_t'($urandom);
                pc         <= $urandom;
                mret_valid <= 1'b1;
            end
            @(negedge clk);
            if (n > 8) begin
                $display("** FAIL **");
                $fatal(1, "%s: no redirect arrived within 8 cycles", name);
            end
        end
        check_word({name, " latency"}, xlen_t'(cycles), xlen_t'(n));
        check_bit({name, " busy"}, 1'b1, busy);
    endtask

    initial begin
        wait (table_ready);
        #(entries.size() * 10 * CLK_PERIOD);
        $display("** FAIL **");
        $fatal(1, "Timeout: the test table did not finish in time");
    end

    initial begin
        entry_t e;
        xlen_t  old;
        void'($urandom(8));
        rst_n      = 1'b0;
        csr_valid  = 1'b0;
        csr_op     = CSR_RW;
        csr_addr   = '0;
        csr_src    = '0;
        pc         = '0;
        exc_valid  = 1'b0;
        exc_cause  = '0;
        mret_valid = 1'b0;
        m_status   = 32'h0000_1800;
        m_tvec     = '0;
        m_epc      = '0;
        m_cause    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (entries[i]) begin
            e = entries[i];
            @(posedge clk);
            clear_strobes();
            pc <= e.pc;
            case (e.kind)
                K_CSR: begin
                    csr_valid <= 1'b1;
                    csr_op    <= e.op;
                    csr_addr  <= e.addr;
                    csr_src   <= e.data;
                end
                K_EXC: begin
                    exc_valid <= 1'b1;
                    exc_cause <= e.cause;
                end
                K_MRET: begin
                    mret_valid <= 1'b1;
                end
                default: begin
                end
            endcase
            @(negedge clk);
            case (e.kind)
                K_CSR: begin
                    old = model_read(e.addr);
                    check_word(names[i], old, csr_rdata);
                    if (model_hit(e.addr)) begin
                        model_write(e.addr, apply_op(e.op, old, e.data));
                    end else begin
                        wait_redirect(names[i], 3, e.nest);
                        check_word({names[i], " redirect_pc"}, m_tvec, redirect_pc);
                        model_trap(e.pc, 4'd2);
                    end
                end
                K_EXC: begin
                    wait_redirect(names[i], 3, e.nest);
                    check_word({names[i], " redirect_pc"}, m_tvec, redirect_pc);
                    model_trap(e.pc, e.cause);
                end
                K_MRET: begin
                    wait_redirect(names[i], 1, e.nest);
                    check_word({names[i], " redirect_pc"}, m_epc, redirect_pc);
                    m_status[MSTATUS_MIE] = m_status[MSTATUS_MPIE];
                    m_status[MSTATUS_MPIE] = 1'b1;
                end
                default: begin
                    check_bit({names[i], " busy"}, 1'b0, busy);
                    check_bit({names[i], " redirect_valid"}, 1'b0, redirect_valid);
                end
            endcase
        end
        @(posedge clk);
        clear_strobes();
        repeat (2) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
